//--- source/qtable_pkg.sv
package qtable_pkg;

    // table geometry
    localparam int NB_FIELDS   = 4;
    localparam int FIELD_TAIL  = 0;
    localparam int FIELD_HEAD  = 1;
    localparam int FIELD_LADDR = 2;
    localparam int FIELD_HADDR = 3;

    localparam int APP_IDX_WIDTH = 4;
    localparam int QUEUE_DEPTH   = 16;

    // host register window
    localparam int PCIE_ADDR_WIDTH = 16;
    // first bit of the queue page index inside the host address
    localparam int PAGE_LSB        = 12;
    localparam int REG_WIDTH       = 32;
    localparam int LANE_BYTES      = 4;

    // memory stage plus output register
    localparam int BRAM_LATENCY = 2;

    typedef logic [REG_WIDTH-1:0]       field_t;
    typedef logic [APP_IDX_WIDTH-1:0]   queue_idx_t;
    typedef logic [PCIE_ADDR_WIDTH-1:0] pcie_addr_t;
    typedef logic [511:0]               line_t;
    typedef logic [63:0]                byteen_t;

    // one request on one port of a table column
    typedef struct packed {
        logic       rd_en;
        logic       wr_en;
        queue_idx_t addr;
        field_t     wr_data;
    } col_req_t;

    // fields of the queue the DMA engine is working on
    typedef struct packed {
        field_t      tail;
        field_t      head;
        logic [63:0] kmem_addr;
    } queue_regs_t;

    // host write after lane decoding, lane i carries field i
    typedef struct packed {
        logic                       valid;
        queue_idx_t                 page;
        logic [NB_FIELDS-1:0]       lane_en;
        field_t [NB_FIELDS-1:0]     lanes;
    } host_wr_t;

    typedef enum logic [2:0] {
        IDLE,
        BRAM_DELAY_1,
        BRAM_DELAY_2,
        SWITCH_QUEUE,
        WAIT_DMA
    } switch_state_t;

endpackage

//--- source/qtable_column.sv
`timescale 1ns/1ps

module qtable_column (
    input  logic                 pcie_clk,
    input  qtable_pkg::col_req_t a,
    input  qtable_pkg::col_req_t b,
    output qtable_pkg::field_t   q_a,
    output qtable_pkg::field_t   q_b
);

    // all queues start with zeroed fields
    qtable_pkg::field_t mem [qtable_pkg::QUEUE_DEPTH] = '{default: '0};

    // first read stage, straight out of the array
    qtable_pkg::field_t mem_q_a;
    qtable_pkg::field_t mem_q_b;

    always_ff @(posedge pcie_clk) begin
        if (a.wr_en) begin
            mem[a.addr] <= a.wr_data;
        end
        if (b.wr_en) begin
            mem[b.addr] <= b.wr_data;
        end

        // reads return the old word on a same-address write
        if (a.rd_en) begin
            mem_q_a <= mem[a.addr];
        end
        if (b.rd_en) begin
            mem_q_b <= mem[b.addr];
        end

        // output register
        q_a <= mem_q_a;
        q_b <= mem_q_b;
    end

    // the queue switch and the host port each use a port for one access at a time
    port_a_single_access: assert property (
        @(posedge pcie_clk) !(a.rd_en && a.wr_en)
    );
    port_b_single_access: assert property (
        @(posedge pcie_clk) !(b.rd_en && b.wr_en)
    );

endmodule

//--- source/qtable_host_port.sv
`timescale 1ns/1ps

module qtable_host_port (
    input  logic                                            pcie_clk,
    input  logic                                            pcie_reset_n,
    input  qtable_pkg::pcie_addr_t                          pcie_address,
    input  logic                                            pcie_write,
    input  logic                                            pcie_read,
    input  qtable_pkg::line_t                               pcie_writedata,
    input  qtable_pkg::byteen_t                             pcie_byteenable,
    output qtable_pkg::col_req_t [qtable_pkg::NB_FIELDS-1:0] col_b,
    output qtable_pkg::host_wr_t                            host_wr,
    output logic                                            rd_issue
);

    qtable_pkg::queue_idx_t               page;
    logic [qtable_pkg::NB_FIELDS-1:0]     lane_en;
    qtable_pkg::field_t [qtable_pkg::NB_FIELDS-1:0] lanes;

    // one outstanding read, waiting for a cycle without a host write
    logic                   rd_pending;
    qtable_pkg::queue_idx_t rd_page;

    assign page = pcie_address[qtable_pkg::PAGE_LSB +: qtable_pkg::APP_IDX_WIDTH];

    // a lane counts only when all of its byte enables are set
    always_comb begin
        for (int i = 0; i < qtable_pkg::NB_FIELDS; i++) begin
            lane_en[i] = &pcie_byteenable[i*qtable_pkg::LANE_BYTES +: qtable_pkg::LANE_BYTES];
            lanes[i]   = pcie_writedata[i*qtable_pkg::REG_WIDTH +: qtable_pkg::REG_WIDTH];
        end
    end

    // the queue switch sees the write in the cycle it is on the bus
    assign host_wr.valid   = pcie_write;
    assign host_wr.page    = page;
    assign host_wr.lane_en = lane_en;
    assign host_wr.lanes   = lanes;

    // shared B port, host writes first, then the pending read
    always_ff @(posedge pcie_clk) begin
        rd_issue <= 1'b0;
        for (int i = 0; i < qtable_pkg::NB_FIELDS; i++) begin
            col_b[i].rd_en <= 1'b0;
            col_b[i].wr_en <= 1'b0;
        end

        if (!pcie_reset_n) begin
            rd_pending <= 1'b0;
        end else begin
            if (pcie_write) begin
                // tail column is written back by the queue switch only
                for (int i = 0; i < qtable_pkg::NB_FIELDS; i++) begin
                    if (i != qtable_pkg::FIELD_TAIL && lane_en[i]) begin
                        col_b[i].wr_en   <= 1'b1;
                        col_b[i].addr    <= page;
                        col_b[i].wr_data <= lanes[i];
                    end
                end
            end else if (rd_pending) begin
                for (int i = 0; i < qtable_pkg::NB_FIELDS; i++) begin
                    col_b[i].rd_en <= 1'b1;
                    col_b[i].addr  <= rd_page;
                end
                rd_pending <= 1'b0;
                rd_issue   <= 1'b1;
            end

            if (pcie_read) begin
                rd_pending <= 1'b1;
                rd_page    <= page;
            end
        end
    end

    // the host waits for readdatavalid before the next read
    one_read_outstanding: assert property (
        @(posedge pcie_clk) disable iff (!pcie_reset_n)
        pcie_read |-> !rd_pending
    );

endmodule

//--- source/qtable_readback.sv
`timescale 1ns/1ps

module qtable_readback (
    input  logic                                           pcie_clk,
    input  logic                                           pcie_reset_n,
    input  logic                                           rd_issue,
    input  qtable_pkg::field_t [qtable_pkg::NB_FIELDS-1:0] q_b,
    output qtable_pkg::line_t                              pcie_readdata,
    output logic                                           pcie_readdatavalid
);

    // issue strobe follows the data through the column pipeline
    logic [qtable_pkg::BRAM_LATENCY-1:0] rd_pipe;

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            rd_pipe            <= '0;
            pcie_readdatavalid <= 1'b0;
        end else begin
            rd_pipe            <= {rd_pipe[qtable_pkg::BRAM_LATENCY-2:0], rd_issue};
            pcie_readdatavalid <= rd_pipe[qtable_pkg::BRAM_LATENCY-1];
        end
    end

    // lanes 0-3 carry the table fields, everything above reads zero
    always_ff @(posedge pcie_clk) begin
        if (rd_pipe[qtable_pkg::BRAM_LATENCY-1]) begin
            pcie_readdata <= '0;
            for (int i = 0; i < qtable_pkg::NB_FIELDS; i++) begin
                pcie_readdata[i*qtable_pkg::REG_WIDTH +: qtable_pkg::REG_WIDTH] <= q_b[i];
            end
        end
    end

endmodule

//--- source/queue_switch.sv
`timescale 1ns/1ps

module queue_switch (
    input  logic                                             pcie_clk,
    input  logic                                             pcie_reset_n,
    input  logic                                             dma_start,
    input  qtable_pkg::queue_idx_t                           dma_queue,
    input  logic                                             dma_done,
    input  qtable_pkg::field_t                               new_tail,
    input  qtable_pkg::host_wr_t                             host_wr,
    input  qtable_pkg::col_req_t [qtable_pkg::NB_FIELDS-1:0] col_b,
    input  qtable_pkg::field_t [qtable_pkg::NB_FIELDS-1:0]   q_a,
    output qtable_pkg::col_req_t [qtable_pkg::NB_FIELDS-1:0] col_a,
    output qtable_pkg::queue_regs_t                          queue_state,
    output logic                                             queue_ready
);

    qtable_pkg::switch_state_t state;

    // loaded queue, invalid out of reset so the first start always loads
    logic                   loaded_vld;
    qtable_pkg::queue_idx_t loaded_q;

    // active queue fields, indexed like the columns
    qtable_pkg::field_t [qtable_pkg::NB_FIELDS-1:0] fields;

    // a-port read in flight per field, cleared when a host write supersedes it
    logic [qtable_pkg::NB_FIELDS-1:0] rd_vld_r1;
    logic [qtable_pkg::NB_FIELDS-1:0] rd_vld_r2;

    assign queue_state.tail      = fields[qtable_pkg::FIELD_TAIL];
    assign queue_state.head      = fields[qtable_pkg::FIELD_HEAD];
    assign queue_state.kmem_addr = {fields[qtable_pkg::FIELD_HADDR],
                                    fields[qtable_pkg::FIELD_LADDR]};

    always_ff @(posedge pcie_clk) begin
        queue_ready <= 1'b0;
        for (int i = 0; i < qtable_pkg::NB_FIELDS; i++) begin
            col_a[i].rd_en <= 1'b0;
            col_a[i].wr_en <= 1'b0;
        end

        if (!pcie_reset_n) begin
            state      <= qtable_pkg::IDLE;
            loaded_vld <= 1'b0;
            fields     <= '0;
            rd_vld_r1  <= '0;
            rd_vld_r2  <= '0;
        end else begin
            for (int i = 0; i < qtable_pkg::NB_FIELDS; i++) begin
                rd_vld_r1[i] <= col_a[i].rd_en;
            end
            rd_vld_r2 <= rd_vld_r1;

            case (state)
                qtable_pkg::IDLE: begin
                    if (dma_start) begin
                        if (loaded_vld && loaded_q == dma_queue) begin
                            queue_ready <= 1'b1;
                            state       <= qtable_pkg::WAIT_DMA;
                        end else begin
                            for (int i = 0; i < qtable_pkg::NB_FIELDS; i++) begin
                                // a write landing on this queue right now is newer
                                // than anything the read would return
                                if (col_b[i].wr_en && col_b[i].addr == dma_queue) begin
                                    fields[i] <= col_b[i].wr_data;
                                end else begin
                                    col_a[i].rd_en <= 1'b1;
                                    col_a[i].addr  <= dma_queue;
                                end
                            end
                            loaded_vld <= 1'b1;
                            loaded_q   <= dma_queue;
                            state      <= qtable_pkg::BRAM_DELAY_1;
                        end
                    end
                end
                qtable_pkg::BRAM_DELAY_1: begin
                    state <= qtable_pkg::BRAM_DELAY_2;
                end
                qtable_pkg::BRAM_DELAY_2: begin
                    state <= qtable_pkg::SWITCH_QUEUE;
                end
                qtable_pkg::SWITCH_QUEUE: begin
                    for (int i = 0; i < qtable_pkg::NB_FIELDS; i++) begin
                        if (rd_vld_r2[i]) begin
                            fields[i] <= q_a[i];
                        end
                    end
                    queue_ready <= 1'b1;
                    state       <= qtable_pkg::WAIT_DMA;
                end
                qtable_pkg::WAIT_DMA: begin
                    if (dma_done) begin
                        fields[qtable_pkg::FIELD_TAIL] <= new_tail;

                        // keep the table in step with the engine
                        col_a[qtable_pkg::FIELD_TAIL].wr_en   <= 1'b1;
                        col_a[qtable_pkg::FIELD_TAIL].addr    <= loaded_q;
                        col_a[qtable_pkg::FIELD_TAIL].wr_data <= new_tail;

                        state <= qtable_pkg::IDLE;
                    end
                end
                default: state <= qtable_pkg::IDLE;
            endcase

            // host writes to the queue in use go straight to the active copy,
            // and any table read still in flight for that field is dropped
            if (host_wr.valid && host_wr.page == dma_queue) begin
                for (int i = 0; i < qtable_pkg::NB_FIELDS; i++) begin
                    if (host_wr.lane_en[i]) begin
                        fields[i]      <= host_wr.lanes[i];
                        col_a[i].rd_en <= 1'b0;
                        rd_vld_r1[i]   <= 1'b0;
                        rd_vld_r2[i]   <= 1'b0;
                    end
                end
            end
        end
    end

    // the DMA engine only finishes a transfer it was given the queue for
    done_only_while_waiting: assert property (
        @(posedge pcie_clk) disable iff (!pcie_reset_n)
        dma_done |-> state == qtable_pkg::WAIT_DMA
    );

endmodule

//--- source/pcie_qtable_top.sv
`timescale 1ns/1ps

module pcie_qtable_top (
    input  logic                    pcie_clk,
    input  logic                    pcie_reset_n,

    // host register window
    input  qtable_pkg::pcie_addr_t  pcie_address,
    input  logic                    pcie_write,
    input  logic                    pcie_read,
    input  qtable_pkg::line_t       pcie_writedata,
    input  qtable_pkg::byteen_t     pcie_byteenable,
    output qtable_pkg::line_t       pcie_readdata,
    output logic                    pcie_readdatavalid,

    // DMA engine side
    input  logic                    dma_start,
    input  qtable_pkg::queue_idx_t  dma_queue,
    input  logic                    dma_done,
    input  qtable_pkg::field_t      new_tail,
    output qtable_pkg::queue_regs_t queue_state,
    output logic                    queue_ready
);

    qtable_pkg::col_req_t [qtable_pkg::NB_FIELDS-1:0] col_a;
    qtable_pkg::col_req_t [qtable_pkg::NB_FIELDS-1:0] col_b;
    qtable_pkg::field_t [qtable_pkg::NB_FIELDS-1:0]   q_a;
    qtable_pkg::field_t [qtable_pkg::NB_FIELDS-1:0]   q_b;
    qtable_pkg::host_wr_t                             host_wr;
    logic                                             rd_issue;

    qtable_host_port qtable_host_port_i (
        .pcie_clk        (pcie_clk),
        .pcie_reset_n    (pcie_reset_n),
        .pcie_address    (pcie_address),
        .pcie_write      (pcie_write),
        .pcie_read       (pcie_read),
        .pcie_writedata  (pcie_writedata),
        .pcie_byteenable (pcie_byteenable),
        .col_b           (col_b),
        .host_wr         (host_wr),
        .rd_issue        (rd_issue)
    );

    // one column per field, port A for the queue switch, port B for the host
    for (genvar i = 0; i < qtable_pkg::NB_FIELDS; i++) begin : g_col
        qtable_column qtable_column_i (
            .pcie_clk (pcie_clk),
            .a        (col_a[i]),
            .b        (col_b[i]),
            .q_a      (q_a[i]),
            .q_b      (q_b[i])
        );
    end

    qtable_readback qtable_readback_i (
        .pcie_clk           (pcie_clk),
        .pcie_reset_n       (pcie_reset_n),
        .rd_issue           (rd_issue),
        .q_b                (q_b),
        .pcie_readdata      (pcie_readdata),
        .pcie_readdatavalid (pcie_readdatavalid)
    );

    queue_switch queue_switch_i (
        .pcie_clk     (pcie_clk),
        .pcie_reset_n (pcie_reset_n),
        .dma_start    (dma_start),
        .dma_queue    (dma_queue),
        .dma_done     (dma_done),
        .new_tail     (new_tail),
        .host_wr      (host_wr),
        .col_b        (col_b),
        .q_a          (q_a),
        .col_a        (col_a),
        .queue_state  (queue_state),
        .queue_ready  (queue_ready)
    );

endmodule

//--- verification/tb_pcie_qtable.sv
`timescale 1ns/1ps

module tb_pcie_qtable;

    localparam time CLK_PERIOD      = 40ns;
    localparam int  NUM_TESTS       = 6;
    localparam int  CYCLES_PER_TEST = 200;
    localparam int  WAIT_LIMIT      = 32;
    // issue edge to readdatavalid with a free port
    localparam int  READ_LATENCY    = 4;
    // dma_start drive to queue_ready, counted in falling edges
    localparam int  LOAD_LATENCY    = 4;
    localparam int  SAME_LATENCY    = 1;

    localparam qtable_pkg::queue_idx_t PAGE_A = 4'd5;
    localparam qtable_pkg::queue_idx_t PAGE_B = 4'd9;

    logic                    pcie_clk = 1'b0;
    logic                    pcie_reset_n;
    qtable_pkg::pcie_addr_t  pcie_address;
    logic                    pcie_write;
    logic                    pcie_read;
    qtable_pkg::line_t       pcie_writedata;
    qtable_pkg::byteen_t     pcie_byteenable;
    qtable_pkg::line_t       pcie_readdata;
    logic                    pcie_readdatavalid;
    logic                    dma_start;
    qtable_pkg::queue_idx_t  dma_queue;
    logic                    dma_done;
    qtable_pkg::field_t      new_tail;
    qtable_pkg::queue_regs_t queue_state;
    logic                    queue_ready;

    logic [31:0] lfsr_state;
    int          cycle_cnt = 0;

    // expected table contents and the queue the switch holds
    qtable_pkg::field_t     model [qtable_pkg::QUEUE_DEPTH][qtable_pkg::NB_FIELDS];
    logic                   loaded_vld;
    qtable_pkg::queue_idx_t loaded_q;

    always #(CLK_PERIOD / 2) pcie_clk = ~pcie_clk;

    always @(posedge pcie_clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    pcie_qtable_top pcie_qtable_top_i (
        .pcie_clk           (pcie_clk),
        .pcie_reset_n       (pcie_reset_n),
        .pcie_address       (pcie_address),
        .pcie_write         (pcie_write),
        .pcie_read          (pcie_read),
        .pcie_writedata     (pcie_writedata),
        .pcie_byteenable    (pcie_byteenable),
        .pcie_readdata      (pcie_readdata),
        .pcie_readdatavalid (pcie_readdatavalid),
        .dma_start          (dma_start),
        .dma_queue          (dma_queue),
        .dma_done           (dma_done),
        .new_tail           (new_tail),
        .queue_state        (queue_state),
        .queue_ready        (queue_ready)
    );

    task automatic abort_run(input string reason);
        $display("ERROR: %s", reason);
        $display("*** FAILED ***");
        $fatal(1, "run stopped");
    endtask

    task automatic check_equal(input string name, input logic [511:0] expected,
                               input logic [511:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1, shifting right
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic random_field(output qtable_pkg::field_t value);
        value = '0;
        for (int i = 0; i < qtable_pkg::REG_WIDTH; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[qtable_pkg::REG_WIDTH-2:0], lfsr_state[0]};
        end
    endtask

    function automatic qtable_pkg::line_t expected_line(input qtable_pkg::queue_idx_t page);
        qtable_pkg::line_t line;
        line = '0;
        for (int i = 0; i < qtable_pkg::NB_FIELDS; i++) begin
            line[i*qtable_pkg::REG_WIDTH +: qtable_pkg::REG_WIDTH] = model[page][i];
        end
        return line;
    endfunction

    function automatic qtable_pkg::queue_regs_t expected_state(
        input qtable_pkg::queue_idx_t page
    );
        qtable_pkg::queue_regs_t regs;
        regs.tail      = model[page][qtable_pkg::FIELD_TAIL];
        regs.head      = model[page][qtable_pkg::FIELD_HEAD];
        regs.kmem_addr = {model[page][qtable_pkg::FIELD_HADDR],
                          model[page][qtable_pkg::FIELD_LADDR]};
        return regs;
    endfunction

    task automatic host_write(input qtable_pkg::queue_idx_t page, input qtable_pkg::line_t data,
                              input qtable_pkg::byteen_t be);
        pcie_write      = 1'b1;
        pcie_address    = '0;
        pcie_address[qtable_pkg::PAGE_LSB +: qtable_pkg::APP_IDX_WIDTH] = page;
        pcie_writedata  = data;
        pcie_byteenable = be;
        // full lanes only, and never the tail column
        for (int i = 0; i < qtable_pkg::NB_FIELDS; i++) begin
            if (i != qtable_pkg::FIELD_TAIL && &be[i*qtable_pkg::LANE_BYTES +: 4]) begin
                model[page][i] = data[i*qtable_pkg::REG_WIDTH +: qtable_pkg::REG_WIDTH];
            end
        end
        @(negedge pcie_clk);
        pcie_write = 1'b0;
    endtask

    task automatic issue_read(input qtable_pkg::queue_idx_t page, output int issue_cycle);
        pcie_read    = 1'b1;
        pcie_address = '0;
        pcie_address[qtable_pkg::PAGE_LSB +: qtable_pkg::APP_IDX_WIDTH] = page;
        @(negedge pcie_clk);
        pcie_read   = 1'b0;
        issue_cycle = cycle_cnt;
    endtask

    task automatic wait_read(input int issue_cycle, output qtable_pkg::line_t data,
                             output int latency);
        while (!pcie_readdatavalid) begin
            if (cycle_cnt - issue_cycle >= WAIT_LIMIT) begin
                abort_run("readdatavalid never came after a host read");
            end
            @(negedge pcie_clk);
        end
        data    = pcie_readdata;
        latency = cycle_cnt - issue_cycle;
    endtask

    task automatic read_and_check(input string name, input qtable_pkg::queue_idx_t page);
        int                issue_cycle;
        int                latency;
        qtable_pkg::line_t data;
        issue_read(page, issue_cycle);
        wait_read(issue_cycle, data, latency);
        check_equal({name, " latency"}, READ_LATENCY, latency);
        check_equal({name, " data"}, expected_line(page), data);
    endtask

    task automatic start_queue(input string name, input qtable_pkg::queue_idx_t queue);
        int   expected_latency;
        int   count;
        logic seen;
        expected_latency = (loaded_vld && loaded_q == queue) ? SAME_LATENCY : LOAD_LATENCY;
        dma_start = 1'b1;
        dma_queue = queue;
        count     = 0;
        seen      = 1'b0;
        while (!seen) begin
            @(negedge pcie_clk);
            dma_start = 1'b0;
            count++;
            if (queue_ready) begin
                seen = 1'b1;
            end else if (count >= WAIT_LIMIT) begin
                abort_run("queue_ready never came after dma_start");
            end
        end
        check_equal({name, " ready latency"}, expected_latency, count);
        loaded_vld = 1'b1;
        loaded_q   = queue;
    endtask

    task automatic finish_dma(input string name, input qtable_pkg::field_t tail);
        dma_done = 1'b1;
        new_tail = tail;
        model[loaded_q][qtable_pkg::FIELD_TAIL] = tail;
        @(negedge pcie_clk);
        dma_done = 1'b0;
        check_equal({name, " tail"}, tail, queue_state.tail);
    endtask

    task automatic test_reset();
        check_equal("reset readdatavalid", 0, pcie_readdatavalid);
        check_equal("reset queue_ready", 0, queue_ready);
        check_equal("reset queue_state", 0, queue_state);
        read_and_check("reset readback", 4'd3);
    endtask

    task automatic test_write_readback();
        qtable_pkg::line_t  data;
        qtable_pkg::field_t value;
        data = '0;
        for (int i = 0; i < qtable_pkg::NB_FIELDS; i++) begin
            random_field(value);
            data[i*qtable_pkg::REG_WIDTH +: qtable_pkg::REG_WIDTH] = value;
        end
        host_write(PAGE_A, data, '1);
        read_and_check("write readback", PAGE_A);
        // lane 2 with its top byte enable missing
        random_field(value);
        data = '0;
        data[2*qtable_pkg::REG_WIDTH +: qtable_pkg::REG_WIDTH] = value;
        host_write(PAGE_A, data, 64'h0000_0700);
        read_and_check("partial write", PAGE_A);
    endtask

    task automatic test_queue_load();
        qtable_pkg::field_t tail;
        start_queue("first load", PAGE_A);
        check_equal("first load state", expected_state(PAGE_A), queue_state);
        random_field(tail);
        finish_dma("first load done", tail);
        start_queue("same queue", PAGE_A);
        check_equal("same queue state", expected_state(PAGE_A), queue_state);
    endtask

    task automatic test_tail_writeback();
        qtable_pkg::field_t tail;
        random_field(tail);
        finish_dma("writeback", tail);
        read_and_check("writeback readback", PAGE_A);
        start_queue("other queue", PAGE_B);
        check_equal("other queue state", expected_state(PAGE_B), queue_state);
        random_field(tail);
        finish_dma("other queue done", tail);
        start_queue("reload", PAGE_A);
        check_equal("reload state", expected_state(PAGE_A), queue_state);
    endtask

    task automatic test_intercept();
        qtable_pkg::line_t       data;
        qtable_pkg::field_t      tail;
        qtable_pkg::field_t      head;
        qtable_pkg::queue_regs_t expected;
        random_field(tail);
        random_field(head);
        data = '0;
        data[qtable_pkg::FIELD_TAIL*qtable_pkg::REG_WIDTH +: qtable_pkg::REG_WIDTH] = tail;
        data[qtable_pkg::FIELD_HEAD*qtable_pkg::REG_WIDTH +: qtable_pkg::REG_WIDTH] = head;
        host_write(PAGE_A, data, 64'h0000_00ff);
        // active copy takes both lanes, the tail column keeps its old word
        expected      = expected_state(PAGE_A);
        expected.tail = tail;
        check_equal("intercept state", expected, queue_state);
        read_and_check("intercept readback", PAGE_A);
    endtask

    task automatic test_write_over_read();
        qtable_pkg::line_t  data;
        qtable_pkg::line_t  expected;
        qtable_pkg::field_t value;
        int                 issue_cycle;
        int                 latency;
        expected = expected_line(PAGE_A);
        issue_read(PAGE_A, issue_cycle);
        for (int w = 0; w < 2; w++) begin
            data = '0;
            for (int i = 0; i < qtable_pkg::NB_FIELDS; i++) begin
                random_field(value);
                data[i*qtable_pkg::REG_WIDTH +: qtable_pkg::REG_WIDTH] = value;
            end
            host_write(PAGE_B, data, '1);
        end
        wait_read(issue_cycle, data, latency);
        check_equal("write over read latency", READ_LATENCY + 2, latency);
        check_equal("write over read data", expected, data);
        read_and_check("write over read page", PAGE_B);
    endtask

    // watchdog sized from the number of tests
    initial begin
        #(CLK_PERIOD * NUM_TESTS * CYCLES_PER_TEST);
        abort_run("timeout, the tests did not finish in time");
    end

    initial begin
        pcie_reset_n    = 1'b0;
        pcie_address    = '0;
        pcie_write      = 1'b0;
        pcie_read       = 1'b0;
        pcie_writedata  = '0;
        pcie_byteenable = '0;
        dma_start       = 1'b0;
        dma_queue       = '0;
        dma_done        = 1'b0;
        new_tail        = '0;
        lfsr_state      = 32'd22;
        loaded_vld      = 1'b0;
        loaded_q        = '0;
        for (int q = 0; q < qtable_pkg::QUEUE_DEPTH; q++) begin
            for (int f = 0; f < qtable_pkg::NB_FIELDS; f++) begin
                model[q][f] = '0;
            end
        end

        repeat (3) @(negedge pcie_clk);
        pcie_reset_n = 1'b1;

        test_reset();
        test_write_readback();
        test_queue_load();
        test_tail_writeback();
        test_intercept();
        test_write_over_read();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- pcie_qtable.f
source/qtable_pkg.sv
source/qtable_column.sv
source/qtable_host_port.sv
source/qtable_readback.sv
source/queue_switch.sv
source/pcie_qtable_top.sv
verification/tb_pcie_qtable.sv

//--- Bender.yml
package:
  name: pcie_qtable

sources:
  # package first, then the leaf modules, then the top level
  - files:
      - source/qtable_pkg.sv
      - source/qtable_column.sv
      - source/qtable_host_port.sv
      - source/qtable_readback.sv
      - source/queue_switch.sv
      - source/pcie_qtable_top.sv

  - target: test
    files:
      - verification/tb_pcie_qtable.sv
